/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_conv_core
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hw/conv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_core (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  conv_pkg::in_word_u         i_data,
    input  logic                       i_valid,
    output logic                       o_ready,
    output logic [conv_pkg::PIX_W-1:0] o_data,
    output logic                       o_valid
);

    conv_pkg::win_beat_t   win;
    conv_pkg::kernel_set_t kernels;
    conv_pkg::sum_beat_t   sum;

    // weights and tile storage, window sequencing
    tile_loader u_loader (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_data    (i_data),
        .i_valid   (i_valid),
        .o_ready   (o_ready),
        .o_win     (win),
        .o_kernels (kernels)
    );

    // one registered sum per window
    conv_stage u_stage (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_win     (win),
        .i_kernels (kernels),
        .o_sum     (sum)
    );

    relu_max_pool u_pool (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_sum   (sum),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

endmodule

`default_nettype wire

/* hw/conv_pe.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_pe (
    input  conv_pkg::pe_grid_t i_pixels,
    input  conv_pkg::pe_grid_t i_weights,
    output conv_pkg::acc_t     o_sum
);

    always_comb
    begin
        conv_pkg::acc_t                    acc;
        conv_pkg::pixel_t                  px;
        conv_pkg::pixel_t                  wt;
        logic signed [2*conv_pkg::PIX_W-1:0] prod;

        acc = '0;
        for (int c = 0; c < conv_pkg::CH_PER_PE; c++)
        begin
            for (int r = 0; r < conv_pkg::K_DIM; r++)
            begin
                for (int k = 0; k < conv_pkg::K_DIM; k++)
                begin
                    px   = i_pixels[c][r][k];
                    wt   = i_weights[c][r][k];
                    // full 16-bit signed product before widening
                    prod = px * wt;
                    acc  = acc + prod;
                end
            end
        end
        o_sum = acc;
    end

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    localparam int N_CH         = 8;
    localparam int K_DIM        = 3;
    localparam int T_DIM        = 4;
    localparam int PIX_W        = 8;
    localparam int ACC_W        = 23;
    localparam int OUT_SHIFT    = 7;
    localparam int N_PE         = 4;
    localparam int CH_PER_PE    = N_CH / N_PE;
    localparam int KERNEL_BEATS = N_CH * K_DIM * K_DIM;
    localparam int TILE_BEATS   = N_CH * T_DIM * T_DIM / 2;
    localparam int BEAT_W       = $clog2(KERNEL_BEATS);

    typedef logic signed [PIX_W-1:0] pixel_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // tile phase view of the input word
    typedef struct packed {
        pixel_t even_pix;
        pixel_t odd_pix;
    } pixel_pair_t;

    // kernel phase view, weight sits in the low byte
    typedef struct packed {
        logic [PIX_W-1:0] unused;
        pixel_t           weight;
    } weight_word_t;

    typedef union packed {
        pixel_pair_t  pair;
        weight_word_t wt;
    } in_word_u;

    // [channel][row][column]
    typedef pixel_t [N_CH-1:0][K_DIM-1:0][K_DIM-1:0] window_t;
    typedef pixel_t [N_CH-1:0][K_DIM-1:0][K_DIM-1:0] kernel_set_t;

    // slice of a window handled by one PE
    typedef pixel_t [CH_PER_PE-1:0][K_DIM-1:0][K_DIM-1:0] pe_grid_t;

    typedef struct packed {
        logic    valid;
        logic    last;
        window_t win;
    } win_beat_t;

    typedef struct packed {
        logic valid;
        logic last;
        acc_t sum;
    } sum_beat_t;

    typedef enum logic [1:0] {
        ST_KERNEL  = 2'd0,
        ST_TILE    = 2'd1,
        ST_COMPUTE = 2'd2
    } load_state_e;

endpackage

`default_nettype wire

/* hw/conv_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_stage (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  conv_pkg::win_beat_t   i_win,
    input  conv_pkg::kernel_set_t i_kernels,
    output conv_pkg::sum_beat_t   o_sum
);

    conv_pkg::acc_t [conv_pkg::N_PE-1:0] pe_sum;
    conv_pkg::acc_t                      total;
    conv_pkg::acc_t                      sum_q;
    logic                                valid_q;
    logic                                last_q;

    // each PE takes a pair of adjacent channels
    for (genvar g = 0; g < conv_pkg::N_PE; g++)
    begin : g_pe
        conv_pe u_pe (
            .i_pixels  (i_win.win[g*conv_pkg::CH_PER_PE +: conv_pkg::CH_PER_PE]),
            .i_weights (i_kernels[g*conv_pkg::CH_PER_PE +: conv_pkg::CH_PER_PE]),
            .o_sum     (pe_sum[g])
        );
    end

    always_comb
    begin
        total = '0;
        for (int g = 0; g < conv_pkg::N_PE; g++)
        begin
            total = total + pe_sum[g];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            valid_q <= i_win.valid;
            last_q  <= i_win.valid & i_win.last;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_win.valid)
        begin
            sum_q <= total;
        end
    end

    assign o_sum = '{valid: valid_q, last: last_q, sum: sum_q};

endmodule

`default_nettype wire

/* hw/relu_max_pool.sv */
`timescale 1ns/10ps
`default_nettype none

module relu_max_pool (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  conv_pkg::sum_beat_t        i_sum,
    output logic [conv_pkg::PIX_W-1:0] o_data,
    output logic                       o_valid
);

    conv_pkg::acc_t             max_q;
    conv_pkg::acc_t             base;
    logic [conv_pkg::ACC_W-1:0] scaled;
    logic                       first_q;
    logic                       last_q;

    // zero floor at tile start gives the rectifier for free
    assign base = first_q ? conv_pkg::acc_t'(0) : max_q;

    // max_q never goes negative, plain shift is enough
    assign scaled = max_q >> conv_pkg::OUT_SHIFT;

    always_ff @(posedge i_clk)
    begin
        if (i_sum.valid)
        begin
            max_q <= (i_sum.sum > base) ? i_sum.sum : base;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            first_q <= 1'b1;
            last_q  <= 1'b0;
            o_valid <= 1'b0;
            o_data  <= '0;
        end
        else
        begin
            last_q  <= i_sum.valid & i_sum.last;
            o_valid <= last_q;
            if (i_sum.valid)
            begin
                first_q <= i_sum.last;
            end
            if (last_q)
            begin
                // saturate to 255
                if (scaled > conv_pkg::ACC_W'(255))
                begin
                    o_data <= '1;
                end
                else
                begin
                    o_data <= scaled[conv_pkg::PIX_W-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/tile_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_loader (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  conv_pkg::in_word_u     i_data,
    input  logic                   i_valid,
    output logic                   o_ready,
    output conv_pkg::win_beat_t    o_win,
    output conv_pkg::kernel_set_t  o_kernels
);

    conv_pkg::load_state_e       state_q;
    logic [conv_pkg::BEAT_W-1:0] beat_q;
    logic [2:0]                  ch_q;
    logic [1:0]                  row_q;
    logic [1:0]                  col_q;
    logic [1:0]                  pos_q;

    conv_pkg::kernel_set_t kern_q;
    conv_pkg::pixel_t [conv_pkg::N_CH-1:0][conv_pkg::T_DIM-1:0][conv_pkg::T_DIM-1:0] tile_q;
    conv_pkg::window_t     win_d;

    logic in_kernel;
    logic in_tile;
    logic accept;
    logic phase_done;
    logic col_wrap;
    logic row_wrap;
    logic row_off;
    logic col_off;

    assign in_kernel = (state_q == conv_pkg::ST_KERNEL);
    assign in_tile   = (state_q == conv_pkg::ST_TILE);
    assign o_ready   = (state_q != conv_pkg::ST_COMPUTE);
    assign accept    = i_valid & o_ready;

    // kernel beats walk a 3x3 grid, tile beats walk 4 rows of 2 column pairs
    assign col_wrap = in_kernel ? (col_q == 2'(conv_pkg::K_DIM - 1))
                                : (col_q == 2'(conv_pkg::T_DIM / 2 - 1));
    assign row_wrap = in_kernel ? (row_q == 2'(conv_pkg::K_DIM - 1))
                                : (row_q == 2'(conv_pkg::T_DIM - 1));

    assign phase_done = in_kernel
        ? (beat_q == conv_pkg::BEAT_W'(conv_pkg::KERNEL_BEATS - 1))
        : (beat_q == conv_pkg::BEAT_W'(conv_pkg::TILE_BEATS - 1));

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            state_q <= conv_pkg::ST_KERNEL;
            beat_q  <= '0;
            ch_q    <= '0;
            row_q   <= '0;
            col_q   <= '0;
            pos_q   <= '0;
        end
        else if (state_q == conv_pkg::ST_COMPUTE)
        begin
            // four window offsets, then back to loading
            pos_q <= pos_q + 2'd1;
            if (pos_q == 2'd3)
            begin
                state_q <= conv_pkg::ST_TILE;
            end
        end
        else if (accept)
        begin
            if (phase_done)
            begin
                beat_q  <= '0;
                state_q <= in_kernel ? conv_pkg::ST_TILE : conv_pkg::ST_COMPUTE;
            end
            else
            begin
                beat_q <= beat_q + 1'b1;
            end

            if (col_wrap)
            begin
                col_q <= '0;
                if (row_wrap)
                begin
                    row_q <= '0;
                    ch_q  <= ch_q + 3'd1;
                end
                else
                begin
                    row_q <= row_q + 2'd1;
                end
            end
            else
            begin
                col_q <= col_q + 2'd1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept && in_kernel)
        begin
            kern_q[ch_q][row_q][col_q] <= i_data.wt.weight;
        end
        if (accept && in_tile)
        begin
            tile_q[ch_q][row_q][{col_q[0], 1'b0}] <= i_data.pair.even_pix;
            tile_q[ch_q][row_q][{col_q[0], 1'b1}] <= i_data.pair.odd_pix;
        end
    end

    // pos order (0,0) (1,0) (0,1) (1,1) as (col, row)
    assign col_off = pos_q[0];
    assign row_off = pos_q[1];

    always_comb
    begin
        for (int c = 0; c < conv_pkg::N_CH; c++)
        begin
            for (int r = 0; r < conv_pkg::K_DIM; r++)
            begin
                for (int k = 0; k < conv_pkg::K_DIM; k++)
                begin
                    win_d[c][r][k] = tile_q[c][r + row_off][k + col_off];
                end
            end
        end
    end

    assign o_win = '{
        valid: (state_q == conv_pkg::ST_COMPUTE),
        last:  (state_q == conv_pkg::ST_COMPUTE) && (pos_q == 2'd3),
        win:   win_d
    };

    assign o_kernels = kern_q;

endmodule

`default_nettype wire

/* test/conv_input.txt */
// first value is the tile count, then 72 weights by channel, row, column
// each tile: expected output byte, then 128 pixels by channel, row, column (two channels a line)
05 // number of tiles
04 00 00 00 00 fc 00 08 00 08 00 00 00 00 f8 00 10 00
0c 00 00 00 00 f4 00 18 00 10 00 00 00 00 f0 00 20 00
14 00 00 00 00 ec 00 28 00 18 00 00 00 00 e8 00 30 00
1c 00 00 00 00 e4 00 38 00 20 00 00 00 00 e0 00 40 00
1c // small positive, max 3600 at (1,1), filler in unused cells
00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f 00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f
00 00 00 55 00 64 00 00 80 00 00 00 00 00 00 7f 00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f
00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f 00 0a 00 55 00 00 00 00 80 00 00 00 00 00 32 7f
00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f 00 00 00 55 00 00 00 00 80 00 00 00 00 00 00 7f
00 // all four sums -2304
f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00 f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00
f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00 f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00
f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00 f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00
f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00 f0 f0 7f 00 f0 f0 00 00 00 00 00 00 00 00 00 00
ff // max 36576, saturates
00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00
0e // sums 480 200 1820 -500
00 00 00 00 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0a 00 00
00 00 aa 00 00 00 00 00 00 00 00 00 33 00 00 00 32 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 05 00 00 00 00 00 00 00 aa 00 00 00 00 00 00 00 00 00 33 00 00 00
00 00 00 00 3c 00 00 00 00 00 00 fb 00 00 00 00 00 00 00 00 00 ec 0a 00 00 00 00 00 00 00 00 00
ed // max 30460 at (1,1), just under 238
80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 f6 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 7f 00 00 00 00 00 80 00 00 7f 00 00 00 00 00 00 7f 00 00 00 00 00 80 00 00 7f 00

/* test/tb_conv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_conv_core;

    localparam int MAX_GAP   = 3;
    localparam int PASSES    = 2;
    localparam int KERN_BASE = 1;
    localparam int TILE_BASE = KERN_BASE + conv_pkg::KERNEL_BEATS;
    localparam int TILE_REC  = 1 + 2 * conv_pkg::TILE_BEATS;

    logic               i_clk = 1'b0;
    logic               i_rst;
    conv_pkg::in_word_u i_data;
    logic               i_valid;
    logic               o_ready;
    logic [7:0]         o_data;
    logic               o_valid;

    // count, kernel set, then per tile the expected byte and 128 pixels
    logic [7:0]  stim [0:1023];
    logic [31:0] rng;
    int          n_tiles;
    int          cycles = 0;
    int          limit_cycles = 0;
    logic [7:0]  exp_q [$];
    // edge index of each tile's last accepted beat
    int          done_q [$];

    conv_core UUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // returns at the negedge before the edge that takes the beat
    task automatic send_beat(input logic [15:0] word, input logic held, input int exp_wait);
        int gap;
        int waits;

        gap   = 0;
        waits = 0;
        if (!held)
        begin
            rng = lcg_next(rng);
            gap = int'(rng[17:16]);
        end
        repeat (gap)
        begin
            @(posedge i_clk);
            i_valid <= 1'b0;
        end
        @(posedge i_clk);
        i_data  <= word;
        i_valid <= 1'b1;
        @(negedge i_clk);
        while (!o_ready)
        begin
            waits++;
            @(negedge i_clk);
        end
        // stall length only meaningful with i_valid held high
        if (held)
        begin
            check_value("stall cycles before beat", waits, exp_wait);
        end
    endtask

    task automatic send_tile(input int t, input logic held);
        int base;
        int j;

        base = TILE_BASE + t * TILE_REC;
        for (j = 0; j < conv_pkg::TILE_BEATS; j++)
        begin
            send_beat({stim[base + 1 + 2*j], stim[base + 2 + 2*j]}, held, (j == 0) ? 4 : 0);
        end
        done_q.push_back(cycles + 1);
        exp_q.push_back(stim[base]);
    endtask

    // output monitor
    always @(negedge i_clk)
    begin
        if (o_valid)
        begin
            if (exp_q.size() == 0 || done_q.size() == 0)
            begin
                $display("o_valid pulsed at %0t ns with no tile outstanding", $time);
                $display("RESULT: FAIL");
                $fatal(1, "unexpected output");
            end
            else
            begin
                check_value("output byte", int'(o_data), int'(exp_q.pop_front()));
                check_value("edges from last beat to o_valid", cycles - done_q.pop_front(), 6);
            end
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge i_clk);
        $display("timeout: run did not finish within %0d clock cycles", limit_cycles);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        i_rst   = 1'b0;
        i_valid = 1'b0;
        i_data  = '0;
        rng     = 32'h4e38_92a1;
        $readmemh("test/conv_input.txt", stim);
        n_tiles = int'(stim[0]);
        // every beat may see the worst gap, each tile adds its compute stall
        limit_cycles = (conv_pkg::KERNEL_BEATS + PASSES * n_tiles * conv_pkg::TILE_BEATS)
                       * (MAX_GAP + 2) + PASSES * n_tiles * 8 + 100;

        repeat (4) @(posedge i_clk);
        i_rst <= 1'b1;
        @(negedge i_clk);
        check_value("o_ready after reset", int'(o_ready), 1);
        check_value("o_valid after reset", int'(o_valid), 0);
        check_value("o_data after reset", int'(o_data), 0);

        for (int k = 0; k < conv_pkg::KERNEL_BEATS; k++)
        begin
            send_beat({8'h00, stim[KERN_BASE + k]}, 1'b0, 0);
        end

        // first pass with random gaps, second with i_valid held high
        for (int p = 0; p < PASSES; p++)
        begin
            for (int t = 0; t < n_tiles; t++)
            begin
                send_tile(t, p == 1);
            end
        end
        @(posedge i_clk);
        i_valid <= 1'b0;

        while (exp_q.size() != 0)
        begin
            @(negedge i_clk);
        end
        // a stray extra strobe would still reach the monitor here
        repeat (8) @(negedge i_clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/conv_pkg.sv
hw/tile_loader.sv
hw/conv_pe.sv
hw/conv_stage.sv
hw/relu_max_pool.sv
hw/conv_core.sv
test/tb_conv_core.sv
